//--- logic/if_pkg.sv
// shared types and constants of the instruction fetch stage
// all instructions are 32 bit and word aligned, no compressed support
// vector table alignment is fixed at 256 bytes

`default_nettype none

package if_pkg;

  // byte address or raw instruction word
  typedef logic [31:0] addr_t;

  // next pc source, driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception target kind
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // bit 5 flags an interrupt, bits 4:0 carry the irq id
  typedef logic [5:0] exc_cause_t;

  // low byte of the first fetch after boot
  parameter logic [7:0]  BOOT_OFFSET    = 8'h80;
  // mtvec base keeps only the bits above this
  parameter int unsigned VEC_ALIGN_BITS = 8;
  // sequential pc step
  parameter int unsigned INSTR_BYTES    = 4;

endpackage

`default_nettype wire

//--- logic/fetch_if.sv
// one fetched instruction on its way from the fetch unit to the IF-ID stage
// payload is stable while valid is high and ready is low

`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
  import if_pkg::*;

  logic  valid;
  logic  ready;
  addr_t rdata;
  addr_t addr;
  logic  err;

  // transfer happens on valid & ready
  modport producer (output valid, output rdata, output addr, output err, input ready);
  modport consumer (input valid, input rdata, input addr, input err, output ready);
  // observation only, used by the pc checker
  modport monitor (input valid, input ready, input rdata, input addr, input err);

endinterface

`default_nettype wire

//--- logic/pc_select.sv
// next fetch address and exception vector selection, purely combinational
// mtvec and boot address low bytes are ignored, the vector table is 256B aligned

`timescale 1ns/1ps
`default_nettype none

module pc_select #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  if_pkg::addr_t       boot_addr_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::exc_cause_t  exc_cause_i,
  input  if_pkg::addr_t       branch_target_ex_i,
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  output if_pkg::addr_t       fetch_addr_n_o,
  output logic                csr_mtvec_init_o
);
  import if_pkg::*;

  addr_t vec_base;
  addr_t boot_pc;
  addr_t exc_pc;

  // mtvec with the alignment bits cleared
  assign vec_base = {csr_mtvec_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign boot_pc  = {boot_addr_i[31:8], BOOT_OFFSET};

  ////////////////////////////////////////////////////////////////////////////
  // exception vector
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = vec_base;
      // one word per irq id, bit 5 only marks the cause as an interrupt
      EXC_PC_IRQ:     exc_pc = vec_base + {exc_cause_i[4:0], 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = vec_base;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next pc
  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_ex_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap or from debug mode
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
// single outstanding request fetch engine with a one entry instruction buffer
// bus: req held until gnt, rvalid one or more cycles after gnt, word addresses
// nothing is fetched before the first pc_set

`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  input  logic          pc_set_i,
  input  if_pkg::addr_t fetch_addr_n_i,
  output logic          instr_req_o,
  output if_pkg::addr_t instr_addr_o,
  input  logic          instr_gnt_i,
  input  logic          instr_rvalid_i,
  input  if_pkg::addr_t instr_rdata_i,
  input  logic          instr_bus_err_i,
  output logic          if_busy_o,
  fetch_if.producer     fetch
);
  import if_pkg::*;

  // request side
  addr_t next_addr_q;
  addr_t req_addr_q;
  addr_t redir_addr;
  addr_t issue_addr;
  logic  started_q;
  logic  req_q;
  logic  out_q;
  logic  discard_q;
  // buffer
  logic  buf_valid_q;
  addr_t buf_rdata_q;
  addr_t buf_addr_q;
  logic  buf_err_q;
  // strobes
  logic  xfer;
  logic  buf_free;
  logic  issue;
  logic  grant;
  logic  resp;
  logic  buf_load;

  assign redir_addr = {fetch_addr_n_i[31:2], 2'b00};
  assign issue_addr = pc_set_i ? redir_addr : next_addr_q;

  assign xfer     = buf_valid_q & fetch.ready;
  // buffer is free when empty, leaving now, or flushed by a redirect
  assign buf_free = ~buf_valid_q | xfer | pc_set_i;
  assign issue    = req_i & (started_q | pc_set_i) & ~req_q & ~out_q & buf_free;
  assign grant    = req_q & instr_gnt_i;
  assign resp     = out_q & instr_rvalid_i;
  // stale responses after a redirect are dropped
  assign buf_load = resp & ~discard_q & ~pc_set_i;

  ////////////////////////////////////////////////////////////////////////////
  // request engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      req_q       <= 1'b0;
      out_q       <= 1'b0;
      discard_q   <= 1'b0;
      req_addr_q  <= '0;
      next_addr_q <= '0;
    end else begin
      if (pc_set_i) begin
        started_q <= 1'b1;
      end
      // request stays up until granted, address frozen meanwhile
      if (issue) begin
        req_q      <= 1'b1;
        req_addr_q <= issue_addr;
      end else if (grant) begin
        req_q <= 1'b0;
      end
      if (grant) begin
        out_q <= 1'b1;
      end else if (resp) begin
        out_q <= 1'b0;
      end
      // redirect wins over the sequential step
      if (pc_set_i) begin
        next_addr_q <= redir_addr;
      end else if (grant && !discard_q) begin
        next_addr_q <= req_addr_q + addr_t'(INSTR_BYTES);
      end
      // mark the in-flight access as stale
      if (pc_set_i && (req_q || (out_q && !instr_rvalid_i))) begin
        discard_q <= 1'b1;
      end else if (resp) begin
        discard_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // one entry buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (buf_load) begin
      buf_valid_q <= 1'b1;
    end else if (xfer || pc_set_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_load) begin
      buf_rdata_q <= instr_rdata_i;
      buf_addr_q  <= req_addr_q;
      buf_err_q   <= instr_bus_err_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign if_busy_o    = req_q | out_q;

  assign fetch.valid = buf_valid_q;
  assign fetch.rdata = buf_rdata_q;
  assign fetch.addr  = buf_addr_q;
  assign fetch.err   = buf_err_q;

endmodule

`default_nettype wire

//--- logic/if_id_regs.sv
// IF-ID pipeline register, loads on every accepted instruction
// a redirect in the transfer cycle squashes the valid flag, data still loads

`timescale 1ns/1ps
`default_nettype none

module if_id_regs (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          id_in_ready_i,
  input  logic          pc_set_i,
  input  logic          instr_valid_clear_i,
  output logic          instr_valid_id_o,
  output logic          instr_new_id_o,
  output if_pkg::addr_t instr_rdata_id_o,
  output logic          instr_fetch_err_o,
  output if_pkg::addr_t pc_id_o,
  fetch_if.consumer     fetch
);

  logic xfer;
  logic valid_d;
  logic valid_q;
  logic new_q;

  // decode accepts whenever it can take a new instruction
  assign fetch.ready = id_in_ready_i;
  assign xfer        = fetch.valid & id_in_ready_i;

  // set by a surviving transfer, held until the controller clears it
  assign valid_d = (xfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  ////////////////////////////////////////////////////////////////////////////
  // flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // single cycle pulse after each transfer
      new_q   <= xfer;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else if (xfer) begin
      instr_rdata_id_o  <= fetch.rdata;
      instr_fetch_err_o <= fetch.err;
      pc_id_o           <= fetch.addr;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

`default_nettype wire

//--- logic/pc_incr_check.sv
// run time check that sequential fetches advance by one word
// no check right after reset, a redirect or a faulting fetch

`timescale 1ns/1ps
`default_nettype none

module pc_incr_check (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          pc_set_i,
  input  if_pkg::addr_t pc_id_i,
  output logic          pc_mismatch_alert_o,
  fetch_if.monitor      fetch
);
  import if_pkg::*;

  logic  xfer;
  logic  seq_d;
  logic  seq_q;
  addr_t pc_expected;

  assign xfer = fetch.valid & fetch.ready;

  // sequential once an instruction is in ID, lost on redirect or bus error
  assign seq_d = (seq_q | xfer) & ~pc_set_i & ~(xfer & fetch.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_expected = pc_id_i + addr_t'(INSTR_BYTES);

  // compare the waiting instruction against the one held in ID
  assign pc_mismatch_alert_o = seq_q & fetch.valid & (fetch.addr != pc_expected);

endmodule

`default_nettype wire

//--- logic/if_stage.sv
// instruction fetch stage top, plain request/grant/rvalid instruction bus
// boot address must be 256B aligned, first fetch is at boot_addr + 0x80
// no instruction cache, no compressed instructions

`timescale 1ns/1ps
`default_nettype none

module if_stage #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  if_pkg::addr_t       boot_addr_i,
  input  logic                req_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::addr_t       instr_rdata_i,
  input  logic                instr_bus_err_i,
  // to ID
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::addr_t       instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_if_o,
  output if_pkg::addr_t       pc_id_o,
  // control
  input  logic                instr_valid_clear_i,
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::exc_cause_t  exc_cause_i,
  input  if_pkg::addr_t       branch_target_ex_i,
  // csrs
  input  if_pkg::addr_t       csr_mepc_i,
  input  if_pkg::addr_t       csr_depc_i,
  input  if_pkg::addr_t       csr_mtvec_i,
  output logic                csr_mtvec_init_o,
  input  logic                id_in_ready_i,
  output logic                pc_mismatch_alert_o,
  output logic                if_busy_o
);
  import if_pkg::*;

  addr_t fetch_addr_n;

  fetch_if fetch_bus ();

  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .boot_addr_i, .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .exc_cause_i, .branch_target_ex_i,
    .csr_mepc_i, .csr_depc_i, .csr_mtvec_i,
    .fetch_addr_n_o (fetch_addr_n),
    .csr_mtvec_init_o
  );

  fetch_unit u_fetch_unit (
    .clk_i, .rst_ni, .req_i, .pc_set_i,
    .fetch_addr_n_i (fetch_addr_n),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .instr_bus_err_i, .if_busy_o,
    .fetch          (fetch_bus.producer)
  );

  if_id_regs u_if_id_regs (
    .clk_i, .rst_ni, .id_in_ready_i, .pc_set_i, .instr_valid_clear_i,
    .instr_valid_id_o, .instr_new_id_o, .instr_rdata_id_o, .instr_fetch_err_o, .pc_id_o,
    .fetch          (fetch_bus.consumer)
  );

  pc_incr_check u_pc_incr_check (
    .clk_i, .rst_ni, .pc_set_i,
    .pc_id_i        (pc_id_o),
    .pc_mismatch_alert_o,
    .fetch          (fetch_bus.monitor)
  );

  // address of the instruction waiting in the fetch buffer
  assign pc_if_o = fetch_bus.addr;

endmodule

`default_nettype wire

//--- tb/tb_if_stage.sv
// testbench for the fetch stage, bus memory model returns addr ^ 32'h5a5a_0000
// bus error on every word with address bits 11:8 equal to 4'he
// checks are concurrent assertions fed by a negedge scoreboard

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;
  import if_pkg::*;

  localparam logic [31:0] HALT_ADDR    = 32'h1A11_0800;
  localparam logic [31:0] DBG_EXC_ADDR = 32'h1A11_0808;
  localparam logic [31:0] DATA_KEY     = 32'h5a5a_0000;
  localparam int          NUM_INSTR    = 300;
  localparam int          TIMEOUT      = 20 * NUM_INSTR + 200;

  logic clk_i, rst_ni, req_i, instr_gnt_i, instr_rvalid_i, instr_bus_err_i;
  logic instr_valid_clear_i, pc_set_i, id_in_ready_i;
  logic [31:0] boot_addr_i, instr_rdata_i, branch_target_ex_i;
  logic [31:0] csr_mepc_i, csr_depc_i, csr_mtvec_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  logic [5:0]  exc_cause_i;
  logic instr_req_o, instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic csr_mtvec_init_o, pc_mismatch_alert_o, if_busy_o;
  logic [31:0] instr_addr_o, instr_rdata_id_o, pc_if_o, pc_id_o;

  integer      seed = 32'hadfd_9942;
  int          cycles = 0;
  int          n_instr = 0;
  int          redir_idx = 0;
  int          gap = 0;
  // memory model, cycles left until rvalid and the granted address
  int          rsp_cnt = 0;
  logic [31:0] rsp_addr = '0;
  // scoreboard
  logic [31:0] exp_pc = '0;
  logic [31:0] old_pc = '0;
  logic [31:0] chk_pc = '0;
  logic [31:0] pc_if_prev = '0;
  logic        exp_valid = 1'b0;
  logic        set_prev = 1'b0;
  logic        clear_prev = 1'b0;
  logic        booted = 1'b0;
  logic        req_seen = 1'b0;
  logic        first_req = 1'b0;

  if_stage #(.DmHaltAddr(HALT_ADDR), .DmExceptionAddr(DBG_EXC_ADDR)) uut (.*);

  always #2 clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("timeout after %0d cycles with %0d instructions seen", cycles, n_instr);
      stop_on_error();
    end
  end

  // fetch buffer address one cycle back, this is the word that moved to ID
  always @(posedge clk_i) begin
    pc_if_prev <= pc_if_o;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference for the redirect address
  function automatic logic [31:0] redirect_target();
    logic [31:0] vec;
    vec = csr_mtvec_i & 32'hffff_ff00;
    case (pc_mux_i)
      PC_BOOT: return (boot_addr_i & 32'hffff_ff00) | 32'h80;
      PC_JUMP: return branch_target_ex_i;
      PC_ERET: return csr_mepc_i;
      PC_DRET: return csr_depc_i;
      default: begin
        case (exc_pc_mux_i)
          EXC_PC_IRQ: return vec + 32'(exc_cause_i[4:0]) * 4;
          EXC_PC_DBD: return HALT_ADDR;
          EXC_PC_DBG_EXC: return DBG_EXC_ADDR;
          default: return vec;
        endcase
      end
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus, bus model and controller share one process and one seed
  task automatic drive_bus();
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_bus_err_i = 1'b0;
    if (rsp_cnt != 0) begin
      rsp_cnt = rsp_cnt - 1;
      if (rsp_cnt == 0) begin
        instr_rvalid_i  = 1'b1;
        instr_rdata_i   = rsp_addr ^ DATA_KEY;
        instr_bus_err_i = (rsp_addr[11:8] == 4'he);
      end
    end else if (instr_req_o && (($random(seed) & 3) != 0)) begin
      // grant now, response one to four cycles later
      instr_gnt_i = 1'b1;
      rsp_addr    = instr_addr_o;
      rsp_cnt     = 1 + ($random(seed) & 3);
    end
  endtask

  task automatic issue_redirect();
    logic [31:0] r;
    r = $random(seed);
    pc_mux_i           = pc_sel_e'(redir_idx % 5);
    exc_pc_mux_i       = exc_pc_sel_e'((redir_idx / 5) % 4);
    exc_cause_i        = {1'b1, r[4:0]};
    // jump lands just below the error window, mepc inside it
    branch_target_ex_i = {20'h00010, 6'b1101_11, r[9:6], 2'b00};
    csr_mepc_i         = {20'h00002, 4'he, r[15:10], 2'b00};
    // depc carries random low bits that the fetch must drop
    csr_depc_i         = {16'h0003, r[29:16], r[31:30]};
    pc_set_i           = 1'b1;
    redir_idx          = redir_idx + 1;
  endtask

  task automatic drive_ctrl(input logic redirects_on);
    logic [31:0] r;
    r = $random(seed);
    pc_set_i            = 1'b0;
    id_in_ready_i       = (r[1:0] != 2'b00);
    instr_valid_clear_i = (r[3:2] == 2'b00);
    if (redirects_on) begin
      if (gap != 0) begin
        gap = gap - 1;
      end else if (if_busy_o || redir_idx[0]) begin
        // even redirects wait for a request in flight
        issue_redirect();
        gap = 8 + r[8:4];
      end
    end
  endtask

  task automatic step_cycle(input logic redirects_on);
    @(posedge clk_i);
    #1;
    drive_bus();
    drive_ctrl(redirects_on);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard, updated mid cycle where all signals are stable
  always @(negedge clk_i) begin
    if (rst_ni) begin
      first_req = instr_req_o && !req_seen;
      if (instr_req_o) begin
        req_seen = 1'b1;
      end
      exp_valid = (instr_new_id_o && !set_prev) || (exp_valid && !clear_prev);
      if (instr_new_id_o) begin
        n_instr = n_instr + 1;
        // a transfer in the redirect cycle still belongs to the old stream
        if (set_prev) begin
          chk_pc = old_pc;
        end else begin
          chk_pc = exp_pc;
          exp_pc = exp_pc + 4;
        end
      end
      if (pc_set_i) begin
        booted = 1'b1;
        old_pc = exp_pc;
        // fetch addresses are word aligned, low two bits of a target are dropped
        exp_pc = redirect_target() & 32'hffff_fffc;
      end
      set_prev   = pc_set_i;
      clear_prev = instr_valid_clear_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  assert property (@(posedge clk_i) !booted |-> !(instr_req_o || instr_valid_id_o ||
      instr_new_id_o || pc_mismatch_alert_o || csr_mtvec_init_o || if_busy_o))
    else begin
      $display("fetch activity seen before the first redirect");
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      first_req |-> instr_addr_o == ((boot_addr_i & 32'hffff_ff00) | 32'h80))
    else begin
      $display("mismatch instr_addr_o: got %h expected %h", $sampled(instr_addr_o),
               $sampled((boot_addr_i & 32'hffff_ff00) | 32'h80));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else begin
      $display("mismatch instr_addr_o: got %h expected low bits 0", $sampled(instr_addr_o));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else begin
      $display("mismatch csr_mtvec_init_o: got %h expected %h", $sampled(csr_mtvec_init_o),
               $sampled(pc_set_i && pc_mux_i == PC_BOOT));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) instr_new_id_o |-> pc_id_o == chk_pc)
    else begin
      $display("mismatch pc_id_o: got %h expected %h", $sampled(pc_id_o), $sampled(chk_pc));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> pc_if_prev == chk_pc)
    else begin
      $display("mismatch pc_if_o: got %h expected %h", $sampled(pc_if_prev),
               $sampled(chk_pc));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_rdata_id_o == (pc_id_o ^ DATA_KEY))
    else begin
      $display("mismatch instr_rdata_id_o: got %h expected %h", $sampled(instr_rdata_id_o),
               $sampled(pc_id_o ^ DATA_KEY));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_fetch_err_o == (pc_id_o[11:8] == 4'he))
    else begin
      $display("mismatch instr_fetch_err_o: got %h expected %h", $sampled(instr_fetch_err_o),
               $sampled(pc_id_o[11:8] == 4'he));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) instr_valid_id_o == exp_valid)
    else begin
      $display("mismatch instr_valid_id_o: got %h expected %h", $sampled(instr_valid_id_o),
               $sampled(exp_valid));
      stop_on_error();
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !pc_mismatch_alert_o)
    else begin
      $display("mismatch pc_mismatch_alert_o: got %h expected 0", $sampled(pc_mismatch_alert_o));
      stop_on_error();
    end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  initial begin
    clk_i               = 1'b0;
    rst_ni              = 1'b1;
    boot_addr_i         = 32'h0000_8037;
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_cause_i         = '0;
    branch_target_ex_i  = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    // low byte set on purpose, the vector base must ignore it
    csr_mtvec_i         = 32'h0000_4a5d;
    id_in_ready_i       = 1'b1;
    // reset falls before the first rising clock edge
    #1;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    req_i  = 1'b1;
    // idle with req_i high, nothing may be fetched before boot
    repeat (4) step_cycle(1'b0);
    @(posedge clk_i);
    #1;
    drive_bus();
    pc_mux_i = PC_BOOT;
    pc_set_i = 1'b1;
    while (n_instr < NUM_INSTR) step_cycle(1'b1);
    repeat (20) step_cycle(1'b0);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- if_stage.f
logic/if_pkg.sv
logic/fetch_if.sv
logic/pc_select.sv
logic/fetch_unit.sv
logic/if_id_regs.sv
logic/pc_incr_check.sv
logic/if_stage.sv
tb/tb_if_stage.sv

//--- Bender.yml
package:
  name: if_stage

sources:
  # rtl, package and interface first
  - logic/if_pkg.sv
  - logic/fetch_if.sv
  - logic/pc_select.sv
  - logic/fetch_unit.sv
  - logic/if_id_regs.sv
  - logic/pc_incr_check.sv
  - logic/if_stage.sv
  # testbench
  - target: test
    files:
      - tb/tb_if_stage.sv
